// ==== fm_cfg_pkg.sv ====
`default_nettype none

package fm_cfg_pkg;

    // channel code, 0..2 first half, 4..6 second half
    typedef logic [2:0] ch_t;
    typedef logic [1:0] op_t;

    typedef struct packed {
        ch_t ch;
        op_t op;
    } slot_t;

    typedef enum logic [3:0] {
        wk_none,
        wk_dt_mul,
        wk_tl,
        wk_ks_ar,
        wk_am_dr,
        wk_sr,
        wk_sl_rr,
        wk_ssg,
        wk_fnum_lo,
        wk_alg,
        wk_pan,
        wk_keyon
    } wr_kind_t;

    // bit 8 selects channels 4..6
    typedef logic [8:0] reg_addr_t;

    localparam reg_addr_t addr_keyon = 9'h028;

    // upper nibble of the register groups
    localparam logic [3:0] grp_dt_mul = 4'h3;
    localparam logic [3:0] grp_tl     = 4'h4;
    localparam logic [3:0] grp_ks_ar  = 4'h5;
    localparam logic [3:0] grp_am_dr  = 4'h6;
    localparam logic [3:0] grp_sr     = 4'h7;
    localparam logic [3:0] grp_sl_rr  = 4'h8;
    localparam logic [3:0] grp_ssg    = 4'h9;
    localparam logic [3:0] grp_freq   = 4'ha;
    localparam logic [3:0] grp_alg    = 4'hb;

endpackage

`default_nettype wire

// ==== fm_keyon.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_keyon
    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int num_ch = 6
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    kon_merge,
    input  wr_req_t merge_req,
    input  slot_t   slot,
    output logic    keyon
);

    localparam int n = num_ch * 4;

    logic [n-1:0] ring;
    logic [3:0]   mask;
    logic         bit_in;

    // mask bit 0 (din bit 4) is operator 0
    assign mask   = merge_req.data[7:4];
    assign bit_in = kon_merge ? mask[slot.op] : ring[n-1];
    assign keyon  = ring[n-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ring <= '0;
        end else begin
            ring <= {ring[n-2:0], bit_in};
        end
    end

endmodule

`default_nettype wire

// ==== fm_reg_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_reg_decode
    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int num_ch = 6
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr,
    input  reg_addr_t  addr,
    input  logic [7:0] din,
    input  logic       busy,
    output logic       req_valid,
    output wr_req_t    req
);

    wr_kind_t   kind;
    slot_t      target;
    logic       ch_ok;
    logic       fhi_wr;
    logic [5:0] fhi_latch;

    always_comb begin
        kind   = wk_none;
        fhi_wr = 1'b0;
        // operator registers: channel in addr[1:0], operator in addr[3:2]
        target = '{ch: {addr[8], addr[1:0]}, op: addr[3:2]};
        case (addr[7:4])
            grp_dt_mul: kind = wk_dt_mul;
            grp_tl:     kind = wk_tl;
            grp_ks_ar:  kind = wk_ks_ar;
            grp_am_dr:  kind = wk_am_dr;
            grp_sr:     kind = wk_sr;
            grp_sl_rr:  kind = wk_sl_rr;
            grp_ssg:    kind = wk_ssg;
            grp_freq: begin
                target.op = 2'd0;
                // 0xA8 and up belong to the ch3 special mode
                if (!addr[3]) begin
                    if (addr[2]) begin
                        fhi_wr = 1'b1;
                    end else begin
                        kind = wk_fnum_lo;
                    end
                end
            end
            grp_alg: begin
                target.op = 2'd0;
                if (!addr[3]) begin
                    kind = addr[2] ? wk_pan : wk_alg;
                end
            end
            default: begin
                if (addr == addr_keyon) begin
                    kind   = wk_keyon;
                    target = '{ch: din[2:0], op: 2'd0};
                end
            end
        endcase
        // code 3 is a hole, second half absent in 3-channel builds
        ch_ok = (target.ch[1:0] != 2'd3) && ((num_ch == 6) || !target.ch[2]);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= wr && ch_ok && (kind != wk_none);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            req.kind <= kind;
            req.slot <= target;
            req.data <= din;
            req.fhi  <= fhi_latch;
            if (fhi_wr && ch_ok) begin
                fhi_latch <= din[5:0];
            end
        end
    end

    // host must hold off while a write is in flight
    assert property (@(posedge clk) disable iff (!arst_n) wr |-> !busy);

endmodule

`default_nettype wire

// ==== fm_reg_pkg.sv ====
`default_nettype none

package fm_reg_pkg;
    import fm_cfg_pkg::*;

    typedef struct packed {
        logic [2:0] dt1;
        logic [3:0] mul;
        logic [6:0] tl;
        logic [1:0] ks;
        logic [4:0] ar;
        logic       amen;
        logic [4:0] d1r;
        logic [4:0] d2r;
        logic [3:0] sl;
        logic [3:0] rr;
        logic [3:0] ssg;
    } op_regs_t;

    typedef struct packed {
        logic [2:0]  block;
        logic [10:0] fnum;
        logic [2:0]  fb;
        logic [2:0]  alg;
        logic [1:0]  rl;
        logic [1:0]  ams;
        logic [2:0]  pms;
    } ch_regs_t;

    typedef struct packed {
        wr_kind_t   kind;
        slot_t      slot;
        logic [7:0] data;
        // block and fnum[10:8] from the 0xA4 latch
        logic [5:0] fhi;
    } wr_req_t;

    // operators start fully attenuated
    localparam op_regs_t op_regs_rst = '{tl: 7'h7f, default: '0};
    // both speakers on after reset
    localparam ch_regs_t ch_regs_rst = '{rl: 2'b11, default: '0};

    function automatic op_regs_t merge_op(input op_regs_t cur, input wr_req_t r);
        op_regs_t v;
        v = cur;
        case (r.kind)
            wk_dt_mul: begin
                v.dt1 = r.data[6:4];
                v.mul = r.data[3:0];
            end
            wk_tl: v.tl = r.data[6:0];
            wk_ks_ar: begin
                v.ks = r.data[7:6];
                v.ar = r.data[4:0];
            end
            wk_am_dr: begin
                v.amen = r.data[7];
                v.d1r  = r.data[4:0];
            end
            wk_sr: v.d2r = r.data[4:0];
            wk_sl_rr: begin
                v.sl = r.data[7:4];
                v.rr = r.data[3:0];
            end
            wk_ssg: v.ssg = r.data[3:0];
            default: v = cur;
        endcase
        return v;
    endfunction

    function automatic ch_regs_t merge_ch(input ch_regs_t cur, input wr_req_t r);
        ch_regs_t v;
        v = cur;
        case (r.kind)
            wk_fnum_lo: begin
                v.block = r.fhi[5:3];
                v.fnum  = {r.fhi[2:0], r.data};
            end
            wk_alg: begin
                v.fb  = r.data[5:3];
                v.alg = r.data[2:0];
            end
            wk_pan: begin
                v.rl  = r.data[7:6];
                v.ams = r.data[5:4];
                v.pms = r.data[2:0];
            end
            default: v = cur;
        endcase
        return v;
    endfunction

endpackage

`default_nettype wire

// ==== fm_reg_ring.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_reg_ring #(
    parameter type      payload_t = logic [7:0],
    parameter int       stages    = 6,
    parameter payload_t rst_val   = '0
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     merge,
    input  payload_t merge_val,
    output payload_t cur
);

    payload_t sr [stages];

    // tail holds the entry of the current slot
    assign cur = sr[stages-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < stages; i++) begin
                sr[i] <= rst_val;
            end
        end else begin
            // updated entry re-enters at the head
            sr[0] <= merge ? merge_val : sr[stages-1];
            for (int i = 1; i < stages; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== fm_reg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_reg_top
    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int num_ch = 6
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr,
    input  reg_addr_t  addr,
    input  logic [7:0] din,
    output logic       busy,
    output slot_t      slot,
    output logic       zero,
    output logic       keyon,
    output logic       carrier,
    output op_regs_t   op_regs,
    output ch_regs_t   ch_regs
);

    logic    req_valid;
    wr_req_t req;
    logic    op_merge;
    logic    ch_merge;
    logic    kon_merge;
    wr_req_t merge_req;

    fm_reg_decode #(.num_ch(num_ch)) u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .addr      (addr),
        .din       (din),
        .busy      (busy),
        .req_valid (req_valid),
        .req       (req)
    );

    fm_slot_seq #(.num_ch(num_ch)) u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .alg       (ch_regs.alg),
        .slot      (slot),
        .zero      (zero),
        .busy      (busy),
        .op_merge  (op_merge),
        .ch_merge  (ch_merge),
        .kon_merge (kon_merge),
        .merge_req (merge_req),
        .carrier   (carrier)
    );

    // one entry per operator slot
    fm_reg_ring #(
        .payload_t (op_regs_t),
        .stages    (num_ch * 4),
        .rst_val   (op_regs_rst)
    ) u_op_ring (
        .clk       (clk),
        .arst_n    (arst_n),
        .merge     (op_merge),
        .merge_val (merge_op(op_regs, merge_req)),
        .cur       (op_regs)
    );

    // one entry per channel
    fm_reg_ring #(
        .payload_t (ch_regs_t),
        .stages    (num_ch),
        .rst_val   (ch_regs_rst)
    ) u_ch_ring (
        .clk       (clk),
        .arst_n    (arst_n),
        .merge     (ch_merge),
        .merge_val (merge_ch(ch_regs, merge_req)),
        .cur       (ch_regs)
    );

    fm_keyon #(.num_ch(num_ch)) u_keyon (
        .clk       (clk),
        .arst_n    (arst_n),
        .kon_merge (kon_merge),
        .merge_req (merge_req),
        .slot      (slot),
        .keyon     (keyon)
    );

endmodule

`default_nettype wire

// ==== fm_slot_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_slot_seq
    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;
#(
    parameter int num_ch = 6
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  wr_req_t    req,
    input  logic [2:0] alg,
    output slot_t      slot,
    output logic       zero,
    output logic       busy,
    output logic       op_merge,
    output logic       ch_merge,
    output logic       kon_merge,
    output wr_req_t    merge_req,
    output logic       carrier
);

    localparam int sweep = num_ch * 4;

    slot_t      nxt;
    logic       pend_valid;
    wr_req_t    pend;
    logic [1:0] kon_cnt;
    logic       is_op;
    logic       is_ch;
    logic       ch_hit;
    logic       last_hit;

    // channels ascending within an operator, code 3 skipped
    always_comb begin
        nxt = slot;
        if (num_ch == 6) begin
            if (slot.ch == 3'd6) begin
                nxt.ch = 3'd0;
                nxt.op = slot.op + 2'd1;
            end else if (slot.ch[1:0] == 2'd2) begin
                nxt.ch = slot.ch + 3'd2;
            end else begin
                nxt.ch = slot.ch + 3'd1;
            end
        end else begin
            if (slot.ch == 3'd2) begin
                nxt.ch = 3'd0;
                nxt.op = slot.op + 2'd1;
            end else begin
                nxt.ch = slot.ch + 3'd1;
            end
        end
    end

    assign is_op = pend.kind inside {wk_dt_mul, wk_tl, wk_ks_ar, wk_am_dr,
                                     wk_sr, wk_sl_rr, wk_ssg};
    assign is_ch = pend.kind inside {wk_fnum_lo, wk_alg, wk_pan};

    assign ch_hit    = pend_valid && (slot.ch == pend.slot.ch);
    assign op_merge  = ch_hit && is_op && (slot.op == pend.slot.op);
    assign ch_merge  = ch_hit && is_ch;
    assign kon_merge = ch_hit && (pend.kind == wk_keyon);
    // key-on stays pending until all four slots of the channel passed
    assign last_hit  = op_merge || ch_merge || (kon_merge && (kon_cnt == 2'd3));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot       <= '0;
            pend_valid <= 1'b0;
            kon_cnt    <= 2'd0;
        end else begin
            slot <= nxt;
            if (req_valid) begin
                pend_valid <= 1'b1;
                kon_cnt    <= 2'd0;
            end else begin
                if (last_hit) begin
                    pend_valid <= 1'b0;
                end
                if (kon_merge) begin
                    kon_cnt <= kon_cnt + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            pend <= req;
        end
    end

    assign merge_req = pend;
    assign busy      = pend_valid || req_valid;
    assign zero      = (slot.ch == 3'd0) && (slot.op == 2'd0);

    always_comb begin
        case (slot.op)
            2'd0:    carrier = (alg == 3'd7);
            2'd1:    carrier = (alg >= 3'd4);
            2'd2:    carrier = (alg >= 3'd5);
            default: carrier = 1'b1;
        endcase
    end

    // decoder should never hand over a second write
    assert property (@(posedge clk) disable iff (!arst_n) req_valid |-> !pend_valid);

    // one zero pulse per sweep
    assert property (@(posedge clk) disable iff (!arst_n)
        zero |=> !zero [* sweep - 1] ##1 zero);

endmodule

`default_nettype wire

// ==== list.f ====
fm_cfg_pkg.sv
fm_reg_pkg.sv
fm_reg_decode.sv
fm_slot_seq.sv
fm_reg_ring.sv
fm_keyon.sv
fm_reg_top.sv
tb_fm_reg.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    -f list.f --top-module tb_fm_reg -o sim_fm_reg
./obj_dir/sim_fm_reg | tee sim.log
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tb_fm_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_fm_reg
    import fm_cfg_pkg::*;
    import fm_reg_pkg::*;
();

    localparam int num_ch = 6;

    logic       clk;
    logic       arst_n;
    logic       wr;
    reg_addr_t  addr;
    logic [7:0] din;
    logic       busy;
    slot_t      slot;
    logic       zero;
    logic       keyon;
    logic       carrier;
    op_regs_t   op_regs;
    ch_regs_t   ch_regs;

    // expected register contents, indexed by {ch, op} or by channel code
    op_regs_t    op_model  [32];
    ch_regs_t    ch_model  [8];
    logic        kon_model [32];
    logic [31:0] rng;
    int          errors;
    int          tests;
    logic        hung;

    fm_reg_top #(.num_ch(num_ch)) i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (wr),
        .addr    (addr),
        .din     (din),
        .busy    (busy),
        .slot    (slot),
        .zero    (zero),
        .keyon   (keyon),
        .carrier (carrier),
        .op_regs (op_regs),
        .ch_regs (ch_regs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // maps 0..5 onto the channel codes around the hole at 3
    function automatic ch_t pick_ch(input logic [31:0] r);
        logic [31:0] k;
        k = r % 6;
        if (k < 3) begin
            return k[2:0];
        end else begin
            return k[2:0] + 3'd1;
        end
    endfunction

    function automatic logic carrier_of(input logic [2:0] alg, input op_t op);
        logic [3:0] outs;
        // bit n set when operator n reaches the output
        case (alg)
            3'd4:       outs = 4'b1010;
            3'd5, 3'd6: outs = 4'b1110;
            3'd7:       outs = 4'b1111;
            default:    outs = 4'b1000;
        endcase
        return outs[op];
    endfunction

    task automatic finish_run();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    // parks the calling process until the closing report ends the run
    task automatic give_up(input string what);
        $display("timeout: DUT did not respond while %s", what);
        errors++;
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    initial begin
        @(posedge hung);
        finish_run();
    end

    task automatic report_error(input string name, input string what,
                                input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("error: %s %s expected %h actual %h", name, what, exp, act);
    endtask

    task automatic host_write(input reg_addr_t a, input logic [7:0] d);
        int n;
        @(posedge clk);
        wr   <= 1'b1;
        addr <= a;
        din  <= d;
        @(posedge clk);
        wr <= 1'b0;
        n = 0;
        @(negedge clk);
        while (busy) begin
            if (n == 100) give_up("waiting for busy to fall");
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_zero();
        int n;
        n = 0;
        @(negedge clk);
        while (!zero) begin
            if (n == 40) give_up("waiting for the zero pulse");
            n++;
            @(negedge clk);
        end
    endtask

    // compares every slot of one sweep against the model
    task automatic check_sweep(input string name);
        slot_t s;
        wait_zero();
        for (int i = 0; i < num_ch * 4; i++) begin
            s = slot;
            if (op_regs !== op_model[s])
                report_error(name, "op_regs", 64'(op_model[s]), 64'(op_regs));
            if (ch_regs !== ch_model[s.ch])
                report_error(name, "ch_regs", 64'(ch_model[s.ch]), 64'(ch_regs));
            if (keyon !== kon_model[s])
                report_error(name, "keyon", 64'(kon_model[s]), 64'(keyon));
            if (carrier !== carrier_of(ch_model[s.ch].alg, s.op))
                report_error(name, "carrier", 64'(carrier_of(ch_model[s.ch].alg, s.op)),
                             64'(carrier));
            if (busy !== 1'b0)
                report_error(name, "busy", 64'(0), 64'(busy));
            @(negedge clk);
        end
    endtask

    task automatic reset_state();
        tests++;
        check_sweep("reset_state");
    endtask

    task automatic slot_order();
        slot_t exp;
        tests++;
        wait_zero();
        for (int i = 0; i < 2 * num_ch * 4; i++) begin
            exp = '{ch: pick_ch(32'(i % 6)), op: op_t'((i / 6) % 4)};
            if (slot !== exp)
                report_error("slot_order", "slot", 64'(exp), 64'(slot));
            if (zero !== (i % 24 == 0))
                report_error("slot_order", "zero", 64'(i % 24 == 0), 64'(zero));
            @(negedge clk);
        end
    endtask

    task automatic op_write();
        logic [31:0] r;
        logic [3:0]  grp;
        logic [7:0]  d;
        slot_t       s;
        tests++;
        for (int k = 0; k < 10; k++) begin
            r   = xorshift32();
            grp = 4'(3 + r % 7);
            s   = '{ch: pick_ch(r >> 8), op: r[17:16]};
            d   = r[31:24];
            case (grp)
                4'h3: begin
                    op_model[s].dt1 = d[6:4];
                    op_model[s].mul = d[3:0];
                end
                4'h4: op_model[s].tl = d[6:0];
                4'h5: begin
                    op_model[s].ks = d[7:6];
                    op_model[s].ar = d[4:0];
                end
                4'h6: begin
                    op_model[s].amen = d[7];
                    op_model[s].d1r  = d[4:0];
                end
                4'h7: op_model[s].d2r = d[4:0];
                4'h8: begin
                    op_model[s].sl = d[7:4];
                    op_model[s].rr = d[3:0];
                end
                default: op_model[s].ssg = d[3:0];
            endcase
            host_write({s.ch[2], grp, s.op, s.ch[1:0]}, d);
            check_sweep("op_write");
        end
    endtask

    task automatic ch_write();
        logic [31:0] r;
        ch_t         c;
        tests++;
        for (int k = 0; k < 5; k++) begin
            r = xorshift32();
            c = pick_ch(r);
            // frequency high byte goes first and waits in the latch
            host_write({c[2], 4'ha, 2'b01, c[1:0]}, r[15:8]);
            host_write({c[2], 4'ha, 2'b00, c[1:0]}, r[23:16]);
            ch_model[c].block = r[13:11];
            ch_model[c].fnum  = {r[10:8], r[23:16]};
            check_sweep("ch_write");
            r = xorshift32();
            host_write({c[2], 4'hb, 2'b00, c[1:0]}, r[7:0]);
            ch_model[c].fb  = r[5:3];
            ch_model[c].alg = r[2:0];
            check_sweep("ch_write");
            host_write({c[2], 4'hb, 2'b01, c[1:0]}, r[15:8]);
            ch_model[c].rl  = r[15:14];
            ch_model[c].ams = r[13:12];
            ch_model[c].pms = r[10:8];
            check_sweep("ch_write");
        end
    endtask

    task automatic keyon_test();
        logic [31:0] r;
        logic [3:0]  m;
        ch_t         c;
        tests++;
        for (int k = 0; k < 3; k++) begin
            r = xorshift32();
            c = pick_ch(r);
            m = r[11:8];
            for (int o = 0; o < 4; o++) begin
                kon_model[{c, 2'(o)}] = m[o];
            end
            host_write(9'h028, {m, 1'b0, c});
            check_sweep("keyon");
            // key off again
            for (int o = 0; o < 4; o++) begin
                kon_model[{c, 2'(o)}] = 1'b0;
            end
            host_write(9'h028, {4'h0, 1'b0, c});
            check_sweep("keyon");
        end
    endtask

    initial begin
        rng    = 32'h00dd78fa;
        errors = 0;
        tests  = 0;
        hung   = 1'b0;
        arst_n <= 1'b0;
        wr     <= 1'b0;
        addr   <= '0;
        din    <= '0;
        for (int i = 0; i < 32; i++) begin
            op_model[i]  = op_regs_rst;
            kon_model[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            ch_model[i] = ch_regs_rst;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        reset_state();
        slot_order();
        op_write();
        ch_write();
        keyon_test();
        finish_run();
    end

endmodule

`default_nettype wire
